// File: verilog/isa_pkg.sv
package isa_pkg;

    // widths fixed by the instruction set
    localparam int WORD_W   = 64;
    localparam int IMM_W    = 32;
    localparam int SEL_W    = 3;
    localparam int OP_W     = 6;
    localparam int NUM_REGS = 1 << SEL_W;

    // bits between the hilo bit and the immediate
    localparam int PAD_W = WORD_W - IMM_W - 1 - 3 * SEL_W - OP_W;

    typedef logic [WORD_W-1:0] word_t;
    typedef logic [IMM_W-1:0]  imm_t;
    typedef logic [SEL_W-1:0]  reg_sel_t;
    typedef logic [OP_W-1:0]   opcode_t;

    // instruction word, msb first
    typedef struct packed {
        imm_t             imm;
        logic [PAD_W-1:0] unused;
        logic             hilo;
        reg_sel_t         dst;
        reg_sel_t         src_b;
        reg_sel_t         src_a;
        opcode_t          op;
    } instr_t;

    typedef enum logic [2:0] {
        FETCH_REQ,
        FETCH_REL,
        EXECUTE,
        STORE_REQ,
        STORE_REL,
        ADVANCE,
        HALTED
    } seq_state_t;

    // register results
    localparam opcode_t OP_LDI   = 6'd0;
    localparam opcode_t OP_ADD   = 6'd1;
    localparam opcode_t OP_SUB   = 6'd2;
    localparam opcode_t OP_AND   = 6'd3;
    localparam opcode_t OP_OR    = 6'd4;
    localparam opcode_t OP_XOR   = 6'd5;
    localparam opcode_t OP_SHL   = 6'd6;

    // src_a goes to the address held in src_b
    localparam opcode_t OP_STORE = 6'd7;

    // flag results
    localparam opcode_t OP_FEQ   = 6'd8;
    localparam opcode_t OP_FLT   = 6'd9;
    localparam opcode_t OP_FAND  = 6'd10;

    // control
    localparam opcode_t OP_JMP   = 6'd11;
    localparam opcode_t OP_JF    = 6'd12;
    localparam opcode_t OP_HALT  = 6'd13;

endpackage

// File: verilog/bus_pkg.sv
package bus_pkg;

    localparam int ADDR_W = 64;
    localparam int DATA_W = 64;

    // memory is addressed in whole words
    typedef logic [ADDR_W-1:0] addr_t;
    typedef logic [DATA_W-1:0] data_t;

    // held stable by the master while req is high
    typedef struct packed {
        addr_t addr;
        data_t wdata;
        logic  write;
    } mem_req_t;

endpackage

// File: verilog/reg_bank.sv
`timescale 1ns/1ps

module reg_bank
    import isa_pkg::*;
(
    input  logic   clock,
    input  logic   rst,
    input  instr_t fields,
    input  logic   reg_we,
    input  word_t  reg_wdata,
    input  logic   flag_we,
    input  logic   flag_wdata,
    output word_t  opnd_a,
    output word_t  opnd_b,
    output logic   flag_a,
    output logic   flag_b
);

    word_t               regs [NUM_REGS];
    logic [NUM_REGS-1:0] flags;

    always_ff @(posedge clock)
    begin
        if (rst)
        begin
            for (int i = 0; i < NUM_REGS; i++)
            begin
                regs[i] <= '0;
            end
            flags <= '0;
        end
        else
        begin
            // both writes target dst, the sequencer only ever raises one
            if (reg_we)
            begin
                regs[fields.dst] <= reg_wdata;
            end
            if (flag_we)
            begin
                flags[fields.dst] <= flag_wdata;
            end
        end
    end

    // read ports, flags share the register selects
    assign opnd_a = regs[fields.src_a];
    assign opnd_b = regs[fields.src_b];
    assign flag_a = flags[fields.src_a];
    assign flag_b = flags[fields.src_b];

endmodule

// File: verilog/exec_unit.sv
`timescale 1ns/1ps

module exec_unit
    import isa_pkg::*;
(
    input  instr_t fields,
    input  word_t  opnd_a,
    input  word_t  opnd_b,
    input  logic   flag_a,
    input  logic   flag_b,
    output word_t  result,
    output logic   flag_result,
    output logic   reg_we,
    output logic   flag_we,
    output logic   pc_load,
    output logic   store,
    output logic   halt
);

    word_t imm_ext;

    assign imm_ext = {{(WORD_W - IMM_W){1'b0}}, fields.imm};

    always_comb
    begin
        result      = '0;
        flag_result = 1'b0;
        reg_we      = 1'b0;
        flag_we     = 1'b0;
        pc_load     = 1'b0;
        store       = 1'b0;
        halt        = 1'b0;

        case (fields.op)
            OP_LDI:
            begin
                reg_we = 1'b1;
                // hilo keeps src_a's low half under the immediate
                if (fields.hilo)
                begin
                    result = {fields.imm, opnd_a[IMM_W-1:0]};
                end
                else
                begin
                    result = imm_ext;
                end
            end
            OP_ADD:
            begin
                reg_we = 1'b1;
                result = opnd_a + opnd_b;
            end
            OP_SUB:
            begin
                reg_we = 1'b1;
                result = opnd_a - opnd_b;
            end
            OP_AND:
            begin
                reg_we = 1'b1;
                result = opnd_a & opnd_b;
            end
            OP_OR:
            begin
                reg_we = 1'b1;
                result = opnd_a | opnd_b;
            end
            OP_XOR:
            begin
                reg_we = 1'b1;
                result = opnd_a ^ opnd_b;
            end
            OP_SHL:
            begin
                reg_we = 1'b1;
                result = opnd_a << opnd_b[5:0];
            end
            OP_STORE:
            begin
                store = 1'b1;
            end
            OP_FEQ:
            begin
                flag_we     = 1'b1;
                flag_result = (opnd_a == opnd_b);
            end
            OP_FLT:
            begin
                flag_we     = 1'b1;
                flag_result = (opnd_a < opnd_b);
            end
            OP_FAND:
            begin
                flag_we     = 1'b1;
                flag_result = flag_a & flag_b;
            end
            // jump target travels on result
            OP_JMP:
            begin
                result  = imm_ext;
                pc_load = 1'b1;
            end
            OP_JF:
            begin
                result  = imm_ext;
                pc_load = flag_a;
            end
            OP_HALT:
            begin
                halt = 1'b1;
            end
            default:
            begin
                result = '0;
            end
        endcase
    end

endmodule

// File: verilog/sequencer.sv
`timescale 1ns/1ps

module sequencer
    import isa_pkg::*;
    import bus_pkg::*;
(
    input  logic     clock,
    input  logic     rst,
    input  logic     ack,
    input  word_t    rdata,
    input  word_t    result,
    input  word_t    opnd_a,
    input  word_t    opnd_b,
    input  logic     reg_we_dec,
    input  logic     flag_we_dec,
    input  logic     pc_load,
    input  logic     store,
    input  logic     halt,
    output logic     req,
    output mem_req_t mem_req,
    output instr_t   fields,
    output logic     reg_we,
    output logic     flag_we,
    output logic     halted
);

    seq_state_t state;
    addr_t      pc;
    instr_t     ir;

    always_ff @(posedge clock)
    begin
        if (rst)
        begin
            state <= FETCH_REQ;
            pc    <= '0;
            req   <= 1'b0;
        end
        else
        begin
            case (state)
                FETCH_REQ:
                begin
                    if (req && ack)
                    begin
                        req   <= 1'b0;
                        state <= FETCH_REL;
                    end
                    else if (!ack)
                    begin
                        // only raise once the previous ack has dropped
                        req <= 1'b1;
                    end
                end
                FETCH_REL:
                begin
                    if (!ack)
                    begin
                        state <= EXECUTE;
                    end
                end
                EXECUTE:
                begin
                    if (halt)
                    begin
                        state <= HALTED;
                    end
                    else if (store)
                    begin
                        state <= STORE_REQ;
                    end
                    else
                    begin
                        state <= ADVANCE;
                    end
                end
                STORE_REQ:
                begin
                    if (req && ack)
                    begin
                        req   <= 1'b0;
                        state <= STORE_REL;
                    end
                    else if (!ack)
                    begin
                        req <= 1'b1;
                    end
                end
                STORE_REL:
                begin
                    if (!ack)
                    begin
                        state <= ADVANCE;
                    end
                end
                ADVANCE:
                begin
                    if (pc_load)
                    begin
                        pc <= result;
                    end
                    else
                    begin
                        pc <= pc + addr_t'(1);
                    end
                    state <= FETCH_REQ;
                end
                default:
                begin
                    // halted until reset
                    req <= 1'b0;
                end
            endcase
        end
    end

    // instruction is taken on the edge where ack is seen
    always_ff @(posedge clock)
    begin
        if (state == FETCH_REQ && req && ack)
        begin
            ir <= instr_t'(rdata);
        end
    end

    // ir and pc do not move while req is up, so the request holds still
    always_comb
    begin
        mem_req.addr  = pc;
        mem_req.wdata = '0;
        mem_req.write = 1'b0;
        if (state == STORE_REQ || state == STORE_REL)
        begin
            mem_req.addr  = opnd_b;
            mem_req.wdata = opnd_a;
            mem_req.write = 1'b1;
        end
    end

    assign fields  = ir;
    assign reg_we  = reg_we_dec && (state == EXECUTE);
    assign flag_we = flag_we_dec && (state == EXECUTE);
    assign halted  = (state == HALTED);

endmodule

// File: verilog/cpu_top.sv
`timescale 1ns/1ps

module cpu_top
    import isa_pkg::*;
    import bus_pkg::*;
(
    input  logic     clock,
    input  logic     rst,
    input  logic     ack,
    input  word_t    rdata,
    output logic     req,
    output mem_req_t mem_req,
    output logic     halted
);

    instr_t fields;
    word_t  opnd_a;
    word_t  opnd_b;
    logic   flag_a;
    logic   flag_b;
    word_t  result;
    logic   flag_result;
    logic   reg_we_dec;
    logic   flag_we_dec;
    logic   pc_load;
    logic   store;
    logic   halt;
    logic   reg_we;
    logic   flag_we;

    sequencer u_sequencer (
        .clock       (clock),
        .rst         (rst),
        .ack         (ack),
        .rdata       (rdata),
        .result      (result),
        .opnd_a      (opnd_a),
        .opnd_b      (opnd_b),
        .reg_we_dec  (reg_we_dec),
        .flag_we_dec (flag_we_dec),
        .pc_load     (pc_load),
        .store       (store),
        .halt        (halt),
        .req         (req),
        .mem_req     (mem_req),
        .fields      (fields),
        .reg_we      (reg_we),
        .flag_we     (flag_we),
        .halted      (halted)
    );

    // writes are gated by the sequencer before they reach the bank
    reg_bank u_reg_bank (
        .clock      (clock),
        .rst        (rst),
        .fields     (fields),
        .reg_we     (reg_we),
        .reg_wdata  (result),
        .flag_we    (flag_we),
        .flag_wdata (flag_result),
        .opnd_a     (opnd_a),
        .opnd_b     (opnd_b),
        .flag_a     (flag_a),
        .flag_b     (flag_b)
    );

    exec_unit u_exec_unit (
        .fields      (fields),
        .opnd_a      (opnd_a),
        .opnd_b      (opnd_b),
        .flag_a      (flag_a),
        .flag_b      (flag_b),
        .result      (result),
        .flag_result (flag_result),
        .reg_we      (reg_we_dec),
        .flag_we     (flag_we_dec),
        .pc_load     (pc_load),
        .store       (store),
        .halt        (halt)
    );

endmodule

// File: tests/cpu_tb.sv
`timescale 1ns/1ps

module cpu_tb
    import isa_pkg::*;
    import bus_pkg::*;
();

    logic     clock;
    logic     rst;
    logic     ack;
    word_t    rdata;
    logic     req;
    mem_req_t mem_req;
    logic     halted;

    word_t  mem [256];
    word_t  prog [256];
    int     plen;
    addr_t  exp_addr [$];
    word_t  exp_data [$];
    addr_t  obs_addr [$];
    word_t  obs_data [$];
    int     store_idx;
    int     errors = 0;
    int     n_pass = 0;
    int     n_fail = 0;
    int     cycles = 0;
    int     cycle_limit = 400;
    integer seed = 14609;

    cpu_top dut (
        .clock   (clock),
        .rst     (rst),
        .ack     (ack),
        .rdata   (rdata),
        .req     (req),
        .mem_req (mem_req),
        .halted  (halted)
    );

    initial
    begin
        clock = 1'b0;
        forever #4 clock = ~clock;
    end

    initial
    begin
        forever
        begin
            @(posedge clock);
            cycles++;
            if (cycles > cycle_limit)
            begin
                $display("timeout: no halt within %0d cycles", cycle_limit);
                $display("TEST RESULT: FAIL");
                $finish;
            end
        end
    end

    // memory side of the handshake, random 0 to 5 cycle delay on both edges of ack
    initial
    begin
        int wait_cnt;
        ack      = 1'b0;
        rdata    = '0;
        wait_cnt = -1;
        forever
        begin
            @(posedge clock);
            #1;
            if (rst)
            begin
                ack      = 1'b0;
                wait_cnt = -1;
            end
            else if (ack)
            begin
                if (!req)
                begin
                    if (wait_cnt < 0)
                    begin
                        wait_cnt = $unsigned($random(seed)) % 6;
                    end
                    if (wait_cnt == 0)
                    begin
                        ack      = 1'b0;
                        wait_cnt = -1;
                    end
                    else
                    begin
                        wait_cnt--;
                    end
                end
            end
            else if (req)
            begin
                if (wait_cnt < 0)
                begin
                    wait_cnt = $unsigned($random(seed)) % 6;
                end
                if (wait_cnt == 0)
                begin
                    if (mem_req.write)
                    begin
                        obs_addr.push_back(mem_req.addr);
                        obs_data.push_back(mem_req.wdata);
                    end
                    else
                    begin
                        rdata = mem[mem_req.addr[7:0]];
                    end
                    ack      = 1'b1;
                    wait_cnt = -1;
                end
                else
                begin
                    wait_cnt--;
                end
            end
        end
    end

    // compares observed stores against the reference list
    initial
    begin
        addr_t a;
        word_t d;
        forever
        begin
            @(posedge clock);
            #2;
            while (obs_addr.size() > 0)
            begin
                a = obs_addr.pop_front();
                d = obs_data.pop_front();
                if (store_idx >= exp_addr.size())
                begin
                    $display("unexpected store of %h to address %h", d, a);
                    errors++;
                end
                else
                begin
                    if (a !== exp_addr[store_idx])
                    begin
                        $display("ERR mem_req.addr store %0d: got %h expected %h",
                                 store_idx, a, exp_addr[store_idx]);
                        errors++;
                    end
                    if (d !== exp_data[store_idx])
                    begin
                        $display("ERR mem_req.wdata store %0d: got %h expected %h",
                                 store_idx, d, exp_data[store_idx]);
                        errors++;
                    end
                end
                store_idx++;
            end
        end
    end

    // handshake rules, sampled after the memory has driven ack
    initial
    begin
        logic     prev_req;
        logic     prev_ack;
        mem_req_t prev_mreq;
        prev_req  = 1'b0;
        prev_ack  = 1'b0;
        prev_mreq = '0;
        forever
        begin
            @(posedge clock);
            #2;
            if (!rst)
            begin
                if (prev_req && !prev_ack && req && mem_req !== prev_mreq)
                begin
                    $display("handshake breach: mem_req changed while req was high and ack low");
                    errors++;
                end
                if (!prev_req && req && prev_ack)
                begin
                    $display("handshake breach: req rose while ack was still high");
                    errors++;
                end
            end
            prev_req  = req;
            prev_ack  = ack;
            prev_mreq = mem_req;
        end
    end

    function automatic word_t enc(opcode_t op, int dst, int a, int b, logic hilo, imm_t imm);
        instr_t i;
        i       = '0;
        i.op    = op;
        i.dst   = reg_sel_t'(dst);
        i.src_a = reg_sel_t'(a);
        i.src_b = reg_sel_t'(b);
        i.hilo  = hilo;
        i.imm   = imm;
        return i;
    endfunction

    // ISA model over prog, fills the expected stores and returns the step count
    function automatic int ref_run();
        word_t      r [8];
        logic [7:0] f;
        word_t      pc;
        instr_t     ins;
        word_t      a;
        word_t      b;
        word_t      imm;
        for (int k = 0; k < 8; k++)
        begin
            r[k] = '0;
        end
        f  = '0;
        pc = '0;
        exp_addr.delete();
        exp_data.delete();
        for (int steps = 1; steps <= 2000; steps++)
        begin
            ins = prog[pc[7:0]];
            a   = r[ins.src_a];
            b   = r[ins.src_b];
            imm = {32'h0, ins.imm};
            pc  = pc + 1;
            case (ins.op)
                OP_LDI: r[ins.dst] = ins.hilo ? {ins.imm, a[31:0]} : imm;
                OP_ADD: r[ins.dst] = a + b;
                OP_SUB: r[ins.dst] = a - b;
                OP_AND: r[ins.dst] = a & b;
                OP_OR: r[ins.dst] = a | b;
                OP_XOR: r[ins.dst] = a ^ b;
                OP_SHL: r[ins.dst] = a << b[5:0];
                OP_STORE:
                begin
                    exp_addr.push_back(b);
                    exp_data.push_back(a);
                end
                OP_FEQ: f[ins.dst] = (a == b);
                OP_FLT: f[ins.dst] = (a < b);
                OP_FAND: f[ins.dst] = f[ins.src_a] & f[ins.src_b];
                OP_JMP: pc = imm;
                OP_JF: pc = f[ins.src_a] ? imm : pc;
                OP_HALT: return steps;
                default: ;
            endcase
        end
        return -1;
    endfunction

    task automatic start_prog();
        plen = 0;
        // unused words decode as a no-op carrying their own address
        for (int i = 0; i < 256; i++)
        begin
            prog[i] = enc(6'h3f, 0, 0, 0, 1'b0, imm_t'(i * 32'h01010101 + 32'h5a00));
        end
    endtask

    task automatic emit(input word_t w);
        prog[plen] = w;
        plen++;
    endtask

    // each register goes to the address held in the next one
    task automatic emit_stores_and_halt();
        for (int i = 0; i < 8; i++)
        begin
            emit(enc(OP_STORE, 0, i, (i + 1) % 8, 1'b0, '0));
        end
        emit(enc(OP_HALT, 0, 0, 0, 1'b0, '0));
    endtask

    task automatic gen_random(input int n);
        int kind;
        int d;
        int a;
        int b;
        for (int i = 0; i < n; i++)
        begin
            kind = $unsigned($random(seed)) % 10;
            if (kind >= 7)
            begin
                kind++;
            end
            d = $unsigned($random(seed)) % 8;
            a = $unsigned($random(seed)) % 8;
            b = $unsigned($random(seed)) % 8;
            emit(enc(opcode_t'(kind), d, a, b, $random(seed) & 1, imm_t'($random(seed))));
        end
    endtask

    task automatic apply_reset();
        @(posedge clock);
        #1;
        rst = 1'b1;
        obs_addr.delete();
        obs_data.delete();
        store_idx = 0;
        repeat (3) @(posedge clock);
        #1;
        rst = 1'b0;
    endtask

    task automatic run_test(input string name);
        int steps;
        int err_before;
        err_before = errors;
        steps      = ref_run();
        if (steps < 0)
        begin
            $display("reference model reached no halt in test %s", name);
            errors++;
            steps = 0;
        end
        cycle_limit += steps * 20 + 80;
        for (int i = 0; i < 256; i++)
        begin
            mem[i] = prog[i];
        end
        apply_reset();
        #1;
        if (req !== 1'b0 || halted !== 1'b0)
        begin
            $display("req or halted not low after reset");
            errors++;
        end
        @(posedge clock);
        #2;
        if (req !== 1'b1)
        begin
            $display("req did not rise on the first cycle after reset");
            errors++;
        end
        if (mem_req.write !== 1'b0)
        begin
            $display("ERR mem_req.write first request: got %h expected 0", mem_req.write);
            errors++;
        end
        if (mem_req.addr !== '0)
        begin
            $display("ERR mem_req.addr first request: got %h expected 0", mem_req.addr);
            errors++;
        end
        while (halted !== 1'b1)
        begin
            @(posedge clock);
            #2;
        end
        repeat (50)
        begin
            @(posedge clock);
            #2;
            if (req !== 1'b0 || halted !== 1'b1)
            begin
                $display("processor left the halted state or raised req after halt");
                errors++;
            end
        end
        if (store_idx != exp_addr.size())
        begin
            $display("saw %0d stores where %0d were expected", store_idx, exp_addr.size());
            errors++;
        end
        if (errors == err_before)
        begin
            n_pass++;
            $display("test %s passed, %0d instructions", name, steps);
        end
        else
        begin
            n_fail++;
            $display("test %s failed with %0d errors", name, errors - err_before);
        end
    endtask

    initial
    begin
        rst = 1'b1;

        start_prog();
        emit(enc(OP_HALT, 0, 0, 0, 1'b0, '0));
        run_test("reset");

        start_prog();
        emit(enc(OP_LDI, 0, 0, 0, 1'b0, 32'h12345678));
        emit(enc(OP_LDI, 1, 0, 0, 1'b1, 32'hdeadbeef));
        emit(enc(OP_LDI, 2, 0, 0, 1'b0, 32'd5));
        emit(enc(OP_ADD, 3, 1, 0, 1'b0, '0));
        emit(enc(OP_SUB, 4, 0, 1, 1'b0, '0));
        emit(enc(OP_AND, 5, 1, 3, 1'b0, '0));
        emit(enc(OP_OR, 6, 4, 2, 1'b0, '0));
        emit(enc(OP_XOR, 7, 6, 1, 1'b0, '0));
        emit(enc(OP_SHL, 0, 1, 2, 1'b0, '0));
        emit_stores_and_halt();
        run_test("arith");

        // addresses 0 to 17 are fixed, jump targets depend on them
        // r2 has its top bit set so a signed compare would flip both FLT results
        start_prog();
        emit(enc(OP_LDI, 0, 0, 0, 1'b0, 32'd7));
        emit(enc(OP_LDI, 1, 0, 0, 1'b0, 32'd7));
        emit(enc(OP_LDI, 2, 0, 0, 1'b1, 32'h80000000));
        emit(enc(OP_FEQ, 1, 0, 1, 1'b0, '0));
        emit(enc(OP_FLT, 2, 2, 0, 1'b0, '0));
        emit(enc(OP_FLT, 3, 0, 2, 1'b0, '0));
        emit(enc(OP_FAND, 4, 1, 3, 1'b0, '0));
        emit(enc(OP_FAND, 5, 1, 2, 1'b0, '0));
        emit(enc(OP_JF, 0, 5, 0, 1'b0, 32'd20));
        emit(enc(OP_STORE, 0, 0, 1, 1'b0, '0));
        emit(enc(OP_JF, 0, 4, 0, 1'b0, 32'd13));
        emit(enc(OP_STORE, 0, 2, 2, 1'b0, '0));
        emit(enc(OP_HALT, 0, 0, 0, 1'b0, '0));
        emit(enc(OP_STORE, 0, 1, 2, 1'b0, '0));
        emit(enc(OP_JMP, 0, 0, 0, 1'b0, 32'd17));
        emit(enc(OP_STORE, 0, 2, 0, 1'b0, '0));
        emit(enc(OP_HALT, 0, 0, 0, 1'b0, '0));
        emit(enc(OP_STORE, 0, 2, 1, 1'b0, '0));
        emit_stores_and_halt();
        run_test("flags");

        start_prog();
        gen_random(30);
        emit_stores_and_halt();
        run_test("handshake");

        start_prog();
        emit(enc(OP_LDI, 1, 0, 0, 1'b0, 32'd3));
        emit(enc(OP_STORE, 0, 1, 1, 1'b0, '0));
        emit(enc(OP_HALT, 0, 0, 0, 1'b0, '0));
        emit(enc(OP_STORE, 0, 1, 0, 1'b0, '0));
        run_test("halt");

        start_prog();
        gen_random(60);
        emit_stores_and_halt();
        run_test("random");

        $display("tests passed %0d, failed %0d", n_pass, n_fail);
        if (n_fail == 0 && errors == 0)
        begin
            $display("TEST RESULT: PASS");
        end
        else
        begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

// File: files.f
verilog/isa_pkg.sv
verilog/bus_pkg.sv
verilog/reg_bank.sv
verilog/exec_unit.sv
verilog/sequencer.sv
verilog/cpu_top.sv
tests/cpu_tb.sv
